// File: sources.f
design/ide_reg_pkg.sv
design/ide_buf_pkg.sv
design/ide_buf_bank.sv
design/ide_buf_merge.sv
design/ide_buf_sequencer.sv
design/ide_task_file.sv
design/ide_channel.sv
testbench/tb_clock.sv
testbench/tb_ide_channel.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --timing
SIM_FLAGS  := $(FLAGS) --binary -j 0
TOP        := tb_ide_channel
RTL_TOP    := ide_channel
FILE_LIST  := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_ide_channel.sv
`timescale 1ns/100ps

module tb_ide_channel;

	localparam int BLK_WORDS = 256;
	localparam int ACC_CYC   = 5;
	localparam int RESET_CYC = 16;
	// Accesses per test: reset, registers, two block transfers, interrupt control.
	localparam int TEST_CYC  = ACC_CYC * (8 + 24 + (2 * BLK_WORDS + 8)
		+ (BLK_WORDS / 2 + BLK_WORDS + 8) + 12) + RESET_CYC + 8;
	localparam int LIMIT_CYC = 5 * TEST_CYC;

	logic        clk;
	logic        rst_n;
	logic [3:0]  io_address;
	logic        io_read;
	logic        io_write;
	logic [31:0] io_writedata;
	logic        io_32;
	logic [31:0] io_readdata;
	logic        io_wait;
	logic [3:0]  mgmt_address;
	logic        mgmt_read;
	logic        mgmt_write;
	logic [15:0] mgmt_writedata;
	logic [15:0] mgmt_readdata;
	logic        use_fast;
	logic        irq;
	logic        drq;
	logic        no_data;
	logic [1:0]  drive_en;
	logic [2:0]  request;

	// Model of the buffer and the task file as the CPU sees it.
	logic [15:0] model_buf [0:BLK_WORDS-1];
	logic [7:0]  m_error = 8'h00;
	logic [15:0] m_count = 16'h0000;
	logic [15:0] m_sector = 16'h0000;
	logic [31:0] m_cyl = 32'h0000_0000;
	logic [7:0]  m_drive = 8'h00;
	logic [7:0]  m_status = 8'h80;
	logic        m_present = 1'b0;
	logic        m_hob_ena = 1'b0;
	logic        m_hob = 1'b0;
	// Wait state enable and the io_wait level it leads to.
	logic        m_use_wait = 1'b0;
	logic        m_wait = 1'b0;

	logic [31:0] io_exp_q [$];
	logic [15:0] mg_exp_q [$];
	logic        io_rd_pend = 1'b0;
	logic        mg_rd_pend = 1'b0;
	int          check_cnt = 0;
	int          err_cnt = 0;
	int          test_checks0;
	int          test_err0;
	int          cycle_cnt;

	tb_clock #(.PERIOD(40), .RESET_CYCLES(RESET_CYC)) u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	ide_channel #(.ADDR_W(12)) DUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.io_address     (io_address),
		.io_read        (io_read),
		.io_write       (io_write),
		.io_writedata   (io_writedata),
		.io_32          (io_32),
		.io_readdata    (io_readdata),
		.io_wait        (io_wait),
		.mgmt_address   (mgmt_address),
		.mgmt_read      (mgmt_read),
		.mgmt_write     (mgmt_write),
		.mgmt_writedata (mgmt_writedata),
		.mgmt_readdata  (mgmt_readdata),
		.use_fast       (use_fast),
		.irq            (irq),
		.drq            (drq),
		.no_data        (no_data),
		.drive_en       (drive_en),
		.request        (request)
	);

	// Expected CPU read of a task file register.
	function automatic logic [31:0] exp_reg_read(input logic [3:0] addr);
		logic [7:0] b;
		case (addr)
			ide_reg_pkg::IO_ERROR:  b = m_error;
			ide_reg_pkg::IO_COUNT:  b = m_hob ? m_count[15:8] : m_count[7:0];
			ide_reg_pkg::IO_SECTOR: b = m_hob ? m_sector[15:8] : m_sector[7:0];
			ide_reg_pkg::IO_CYL_LO: b = m_hob ? m_cyl[23:16] : m_cyl[7:0];
			ide_reg_pkg::IO_CYL_HI: b = m_hob ? m_cyl[31:24] : m_cyl[15:8];
			ide_reg_pkg::IO_DRIVE:  b = m_drive;
			ide_reg_pkg::IO_CMD,
			ide_reg_pkg::IO_ALT:    b = m_status;
			default:                b = 8'h00;
		endcase
		return m_present ? {24'd0, b} : 32'hFFFF_FFFF;
	endfunction

	// An odd 16-bit word appears in both halves of the CPU word.
	function automatic logic [31:0] exp_data_word(input int idx);
		return {model_buf[idx | 1], model_buf[idx]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic cpu_write(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk);
		io_address   <= addr;
		io_writedata <= data;
		io_write     <= 1'b1;
		@(posedge clk);
		io_write <= 1'b0;
		repeat (3) @(posedge clk);
		if (m_present) begin
			case (addr)
				ide_reg_pkg::IO_COUNT:  m_count = {m_count[7:0], data[7:0]};
				ide_reg_pkg::IO_SECTOR: m_sector = {m_sector[7:0], data[7:0]};
				ide_reg_pkg::IO_CYL_LO: {m_cyl[23:16], m_cyl[7:0]} = {m_cyl[7:0], data[7:0]};
				ide_reg_pkg::IO_CYL_HI: {m_cyl[31:24], m_cyl[15:8]} = {m_cyl[15:8], data[7:0]};
				ide_reg_pkg::IO_DRIVE:  m_drive = data[7:0];
				ide_reg_pkg::IO_ALT: begin
					m_hob = data[7] && m_hob_ena && !data[2];
					if (data[2]) begin
						m_status = ide_reg_pkg::ST_BUSY;
						m_wait   = m_use_wait;
					end
				end
				default: ;
			endcase
		end
	endtask

	task automatic cpu_read(input logic [3:0] addr, input logic [31:0] exp);
		io_exp_q.push_back(exp);
		@(posedge clk);
		io_address <= addr;
		io_read    <= 1'b1;
		@(posedge clk);
		io_read <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	task automatic mgmt_write_reg(input logic [3:0] addr, input logic [15:0] data);
		@(posedge clk);
		mgmt_address   <= addr;
		mgmt_writedata <= data;
		mgmt_write     <= 1'b1;
		@(posedge clk);
		mgmt_write <= 1'b0;
		repeat (3) @(posedge clk);
		case (addr)
			ide_reg_pkg::MG_CFG0: m_error = data[15:8];
			ide_reg_pkg::MG_CFG1: begin
				m_count[7:0]  = data[7:0];
				m_sector[7:0] = data[15:8];
			end
			ide_reg_pkg::MG_CFG2: m_cyl[15:0] = data;
			ide_reg_pkg::MG_CFG3: begin
				m_count[15:8]  = data[7:0];
				m_sector[15:8] = data[15:8];
			end
			ide_reg_pkg::MG_CFG4: m_cyl[31:16] = data;
			ide_reg_pkg::MG_CFG6: begin
				if (data[3]) begin
					{m_hob_ena, m_present} = data[1:0];
				end
				if (data[9]) begin
					m_use_wait = data[8];
				end
			end
			default: ;
		endcase
	endtask

	task automatic mgmt_read_reg(input logic [3:0] addr, input logic [15:0] exp);
		mg_exp_q.push_back(exp);
		@(posedge clk);
		mgmt_address <= addr;
		mgmt_read    <= 1'b1;
		@(posedge clk);
		mgmt_read <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	// Status load word: status bits, irq, last_read, and the drive register.
	task automatic load_status(input logic [7:0] st, input logic last, input logic irq_bit);
		mgmt_write_reg(ide_reg_pkg::MG_CFG5,
			{st[7:6], 1'b0, st[4:3], irq_bit, last, st[0], m_drive});
		m_status = st;
		m_wait   = 1'b0;
	endtask

	task automatic check_flags(input logic exp_irq, input logic exp_drq,
		input logic [2:0] exp_req);
		@(negedge clk);
		check_value("irq", irq, exp_irq);
		check_value("drq", drq, exp_drq);
		check_value("request", request, exp_req);
		check_value("io_wait", io_wait, m_wait);
		// Fast read is never requested, so no_data stays low.
		check_value("no_data", no_data, 1'b0);
	endtask

	task automatic start_test;
		test_checks0 = check_cnt;
		test_err0    = err_cnt;
	endtask

	task automatic end_test(input int num, input string name);
		$display("Test %0d %s: %0d checks, %0d errors", num, name,
			check_cnt - test_checks0, err_cnt - test_err0);
	endtask

	// Registered read data is compared one cycle after its strobe.
	always @(negedge clk) begin
		if (io_rd_pend) begin
			check_value("io_readdata", io_readdata, io_exp_q.pop_front());
		end
		if (mg_rd_pend) begin
			check_value("mgmt_readdata", mgmt_readdata, mg_exp_q.pop_front());
		end
		io_rd_pend = io_read;
		mg_rd_pend = mgmt_read;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < LIMIT_CYC) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: test sequence still running after %0d cycles", LIMIT_CYC);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rnd;
		rnd = $urandom(17);
		io_address     <= 4'd0;
		io_read        <= 1'b0;
		io_write       <= 1'b0;
		io_writedata   <= 32'd0;
		io_32          <= 1'b0;
		mgmt_address   <= 4'd0;
		mgmt_read      <= 1'b0;
		mgmt_write     <= 1'b0;
		mgmt_writedata <= 16'd0;
		use_fast       <= 1'b0;
		@(posedge clk);
		while (!rst_n) @(posedge clk);
		repeat (2) @(posedge clk);

		start_test();
		check_flags(1'b0, 1'b0, ide_reg_pkg::RQ_RESET);
		check_value("drive_en", drive_en, 2'b00);
		cpu_read(ide_reg_pkg::IO_CMD, exp_reg_read(ide_reg_pkg::IO_CMD));
		mgmt_write_reg(ide_reg_pkg::MG_CFG6, 16'h0009);
		check_value("drive_en", drive_en, {1'b0, m_present});
		cpu_read(ide_reg_pkg::IO_CMD, exp_reg_read(ide_reg_pkg::IO_CMD));
		end_test(1, "reset state");

		start_test();
		mgmt_write_reg(ide_reg_pkg::MG_CFG0, 16'h5A00);
		mgmt_write_reg(ide_reg_pkg::MG_CFG1, 16'hB2A1);
		mgmt_write_reg(ide_reg_pkg::MG_CFG2, 16'hC4C3);
		mgmt_write_reg(ide_reg_pkg::MG_CFG3, 16'hD2D1);
		mgmt_write_reg(ide_reg_pkg::MG_CFG4, 16'hE6E5);
		cpu_write(ide_reg_pkg::IO_DRIVE, 32'h0000_00E0);
		for (int a = 1; a <= 6; a++) begin
			cpu_read(4'(a), exp_reg_read(4'(a)));
		end
		cpu_write(ide_reg_pkg::IO_COUNT, 32'h0000_0012);
		cpu_write(ide_reg_pkg::IO_COUNT, 32'h0000_0034);
		cpu_read(ide_reg_pkg::IO_COUNT, exp_reg_read(ide_reg_pkg::IO_COUNT));
		// Enable 48-bit mode on drive 0, then select the high bytes.
		mgmt_write_reg(ide_reg_pkg::MG_CFG6, 16'h000B);
		cpu_write(ide_reg_pkg::IO_ALT, 32'h0000_0080);
		for (int a = 2; a <= 5; a++) begin
			cpu_read(4'(a), exp_reg_read(4'(a)));
		end
		cpu_write(ide_reg_pkg::IO_ALT, 32'h0000_0000);
		end_test(2, "register paths");

		start_test();
		// One block of 256 words.
		mgmt_write_reg(ide_reg_pkg::MG_CFG0, 16'h0001);
		for (int i = 0; i < BLK_WORDS; i++) begin
			model_buf[i] = 16'($urandom());
			mgmt_write_reg(ide_reg_pkg::MG_DATA, model_buf[i]);
		end
		load_status(8'h08, 1'b1, 1'b0);
		check_flags(1'b0, 1'b1, ide_reg_pkg::RQ_NONE);
		for (int i = 0; i < BLK_WORDS; i++) begin
			cpu_read(ide_reg_pkg::IO_DATA, exp_data_word(i));
		end
		m_status = ide_reg_pkg::ST_READY;
		m_wait   = m_use_wait;
		cpu_read(ide_reg_pkg::IO_CMD, exp_reg_read(ide_reg_pkg::IO_CMD));
		check_flags(1'b0, 1'b0, ide_reg_pkg::RQ_NONE);
		end_test(3, "management to CPU transfer");

		start_test();
		mgmt_write_reg(ide_reg_pkg::MG_CFG0, 16'h0001);
		load_status(8'h08, 1'b0, 1'b0);
		@(posedge clk);
		io_32 <= 1'b1;
		for (int i = 0; i < BLK_WORDS; i += 2) begin
			rnd = $urandom();
			model_buf[i]     = rnd[15:0];
			model_buf[i + 1] = rnd[31:16];
			cpu_write(ide_reg_pkg::IO_DATA, rnd);
		end
		io_32 <= 1'b0;
		m_status = ide_reg_pkg::ST_BUSY;
		m_wait   = m_use_wait;
		check_flags(1'b0, 1'b0, ide_reg_pkg::RQ_DATA);
		cpu_read(ide_reg_pkg::IO_CMD, exp_reg_read(ide_reg_pkg::IO_CMD));
		for (int i = 0; i < BLK_WORDS; i++) begin
			mgmt_read_reg(ide_reg_pkg::MG_DATA, model_buf[i]);
		end
		end_test(4, "CPU to management transfer");

		start_test();
		load_status(8'h40, 1'b0, 1'b1);
		check_flags(1'b1, 1'b0, ide_reg_pkg::RQ_NONE);
		cpu_read(ide_reg_pkg::IO_CMD, exp_reg_read(ide_reg_pkg::IO_CMD));
		check_flags(1'b0, 1'b0, ide_reg_pkg::RQ_NONE);
		cpu_write(ide_reg_pkg::IO_ALT, 32'h0000_0002);
		load_status(8'h40, 1'b0, 1'b1);
		check_flags(1'b0, 1'b0, ide_reg_pkg::RQ_NONE);
		// Turn on wait states so the software reset raises io_wait.
		mgmt_write_reg(ide_reg_pkg::MG_CFG6, 16'h0309);
		// Pulse the software reset bit.
		cpu_write(ide_reg_pkg::IO_ALT, 32'h0000_0004);
		cpu_write(ide_reg_pkg::IO_ALT, 32'h0000_0000);
		check_flags(1'b0, 1'b0, ide_reg_pkg::RQ_RESET);
		cpu_read(ide_reg_pkg::IO_CMD, exp_reg_read(ide_reg_pkg::IO_CMD));
		end_test(5, "interrupt and reset control");

		$display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset is released on a rising edge, like any other input.
	initial begin
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: design/ide_channel.sv
`timescale 1ns/100ps

module ide_channel #(
	parameter int ADDR_W = 12
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [3:0]  io_address,
	input  logic        io_read,
	input  logic        io_write,
	input  logic [31:0] io_writedata,
	input  logic        io_32,
	output logic [31:0] io_readdata,
	output logic        io_wait,
	input  logic [3:0]  mgmt_address,
	input  logic        mgmt_read,
	input  logic        mgmt_write,
	input  logic [15:0] mgmt_writedata,
	output logic [15:0] mgmt_readdata,
	input  logic        use_fast,
	output logic        irq,
	output logic        drq,
	output logic        no_data,
	output logic [1:0]  drive_en,
	output logic [2:0]  request
);

	logic [31:0] pio_word;
	logic [15:0] mgmt_word;
	logic        io_done;
	logic        pio_wr_stb;
	logic        pio_rd_stb;
	logic [15:0] blk_size;
	logic        fast_read;
	logic        buf_clear;
	logic        io_lsb;
	logic        mgmt_lsb;

	logic [ide_buf_pkg::NUM_BANKS-1:0][ADDR_W-1:0]              bank_addr_a;
	logic [ide_buf_pkg::NUM_BANKS-1:0][ide_buf_pkg::WORD_W-1:0] bank_wdata_a;
	logic [ide_buf_pkg::NUM_BANKS-1:0]                          bank_wren_a;
	logic [ide_buf_pkg::NUM_BANKS-1:0][ADDR_W-1:0]              bank_addr_b;
	logic [ide_buf_pkg::NUM_BANKS-1:0][ide_buf_pkg::WORD_W-1:0] bank_wdata_b;
	logic [ide_buf_pkg::NUM_BANKS-1:0]                          bank_wren_b;
	logic [ide_buf_pkg::NUM_BANKS-1:0][ide_buf_pkg::WORD_W-1:0] q_a;
	logic [ide_buf_pkg::NUM_BANKS-1:0][ide_buf_pkg::WORD_W-1:0] q_b;

	ide_task_file u_task_file (
		.no_data_in (no_data),
		.*
	);

	ide_buf_sequencer #(.ADDR_W(ADDR_W)) u_sequencer (.*);

	// Port a faces the software, port b the CPU.
	for (genvar k = 0; k < ide_buf_pkg::NUM_BANKS; k++) begin : g_bank
		ide_buf_bank #(.ADDR_W(ADDR_W)) u_bank (
			.clk     (clk),
			.addr_a  (bank_addr_a[k]),
			.wdata_a (bank_wdata_a[k]),
			.wren_a  (bank_wren_a[k]),
			.addr_b  (bank_addr_b[k]),
			.wdata_b (bank_wdata_b[k]),
			.wren_b  (bank_wren_b[k]),
			.q_a     (q_a[k]),
			.q_b     (q_b[k])
		);
	end

	ide_buf_merge u_merge (.*);

endmodule

// File: design/ide_task_file.sv
`timescale 1ns/100ps

module ide_task_file (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [3:0]  io_address,
	input  logic        io_read,
	input  logic        io_write,
	input  logic [31:0] io_writedata,
	input  logic        io_32,
	input  logic [3:0]  mgmt_address,
	input  logic        mgmt_read,
	input  logic        mgmt_write,
	input  logic [15:0] mgmt_writedata,
	input  logic        use_fast,
	output logic [31:0] io_readdata,
	output logic        io_wait,
	output logic [15:0] mgmt_readdata,
	output logic        irq,
	output logic        drq,
	output logic [2:0]  request,
	output logic [1:0]  drive_en,
	input  logic [31:0] pio_word,
	input  logic [15:0] mgmt_word,
	input  logic        io_done,
	input  logic        no_data_in,
	output logic        pio_wr_stb,
	output logic        pio_rd_stb,
	output logic [15:0] blk_size,
	output logic        fast_read,
	output logic        buf_clear
);

	logic [7:0]  features;
	logic [7:0]  error;
	logic [15:0] sector_count;
	logic [15:0] sector;
	logic [31:0] cylinder;
	logic [7:0]  drv_addr;
	logic [7:0]  cmd;
	logic [7:0]  status;
	logic [7:0]  reg_byte;
	logic [1:0]  present;
	logic [1:0]  hob_ena;
	logic        use_wait;
	logic        last_read;
	logic        sw_reset;
	logic        disable_irq;
	logic        hob_pre;
	logic        hob;
	logic        tf_reset;
	logic        io_wr;
	logic        st_load;
	logic        cmd_wr;
	logic        alt_wr;
	logic        blk_end;

	assign tf_reset = !rst_n || sw_reset;
	assign io_wr    = io_write && (|present);
	assign st_load  = mgmt_write && (mgmt_address == ide_reg_pkg::MG_CFG5);
	assign cmd_wr   = io_wr && (io_address == ide_reg_pkg::IO_CMD);
	assign alt_wr   = io_wr && (io_address == ide_reg_pkg::IO_ALT);
	assign blk_end  = io_done && drq;

	assign drq        = status[3];
	assign drive_en   = present;
	assign buf_clear  = sw_reset || st_load;
	assign pio_wr_stb = io_wr && (io_address == ide_reg_pkg::IO_DATA) && drq;
	assign pio_rd_stb = io_read && (|present) && (io_address == ide_reg_pkg::IO_DATA) && drq;

	// CPU byte writes shift the previous byte into the high half for 48-bit LBA.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			features     <= 8'h00;
			error        <= 8'h00;
			blk_size     <= 16'h0000;
			sector_count <= 16'd1;
			sector       <= 16'd1;
			cylinder     <= 32'hFFFF_FFFF;
			drv_addr     <= 8'h00;
			cmd          <= 8'h00;
		end else begin
			if (io_wr) begin
				case (io_address)
					ide_reg_pkg::IO_ERROR:  features <= io_writedata[7:0];
					ide_reg_pkg::IO_COUNT:  sector_count <= {sector_count[7:0], io_writedata[7:0]};
					ide_reg_pkg::IO_SECTOR: sector <= {sector[7:0], io_writedata[7:0]};
					ide_reg_pkg::IO_CYL_LO: begin
						{cylinder[23:16], cylinder[7:0]} <= {cylinder[7:0], io_writedata[7:0]};
					end
					ide_reg_pkg::IO_CYL_HI: begin
						{cylinder[31:24], cylinder[15:8]} <= {cylinder[15:8], io_writedata[7:0]};
					end
					ide_reg_pkg::IO_DRIVE:  drv_addr <= io_writedata[7:0];
					ide_reg_pkg::IO_CMD:    cmd <= io_writedata[7:0];
					default: ;
				endcase
			end
			// Software writes come last so they win a same-cycle collision.
			if (mgmt_write) begin
				case (mgmt_address)
					ide_reg_pkg::MG_CFG0: begin
						blk_size <= {mgmt_writedata[7:0], 8'h00};
						error    <= mgmt_writedata[15:8];
					end
					ide_reg_pkg::MG_CFG1: begin
						sector_count[7:0] <= mgmt_writedata[7:0];
						sector[7:0]       <= mgmt_writedata[15:8];
					end
					ide_reg_pkg::MG_CFG2: cylinder[15:0] <= mgmt_writedata;
					ide_reg_pkg::MG_CFG3: begin
						sector_count[15:8] <= mgmt_writedata[7:0];
						sector[15:8]       <= mgmt_writedata[15:8];
					end
					ide_reg_pkg::MG_CFG4: begin
						cylinder[31:16] <= mgmt_writedata;
						// A block size above 32K words is given in full here.
						if (blk_size[15]) begin
							blk_size <= mgmt_writedata;
						end
					end
					ide_reg_pkg::MG_CFG5: drv_addr <= mgmt_writedata[7:0];
					default: ;
				endcase
			end
		end
	end

	// Status, request and the transfer flags move together.
	always_ff @(posedge clk) begin
		if (tf_reset) begin
			status    <= ide_reg_pkg::ST_BUSY;
			request   <= ide_reg_pkg::RQ_RESET;
			last_read <= 1'b0;
			fast_read <= 1'b0;
		end else if (st_load) begin
			status    <= {mgmt_writedata[15:14], 1'b0, mgmt_writedata[12:11], 2'b00,
				mgmt_writedata[8]};
			request   <= ide_reg_pkg::RQ_NONE;
			last_read <= mgmt_writedata[9];
			fast_read <= mgmt_writedata[13];
		end else if (cmd_wr) begin
			status  <= ide_reg_pkg::ST_BUSY;
			request <= ide_reg_pkg::RQ_CMD;
		end else if (blk_end) begin
			status    <= last_read ? ide_reg_pkg::ST_READY : ide_reg_pkg::ST_BUSY;
			last_read <= 1'b0;
			fast_read <= 1'b0;
			if (!last_read) begin
				request <= ide_reg_pkg::RQ_DATA;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			io_wait <= 1'b0;
		end else if (sw_reset || cmd_wr || blk_end) begin
			io_wait <= use_wait;
		end else if (st_load) begin
			io_wait <= 1'b0;
		end
	end

	// Any CPU access to the command register acknowledges the interrupt.
	always_ff @(posedge clk) begin
		if (tf_reset) begin
			irq <= 1'b0;
		end else if (st_load && mgmt_writedata[10] && !disable_irq) begin
			irq <= 1'b1;
		end else if ((io_read || io_wr) && io_address == ide_reg_pkg::IO_CMD) begin
			irq <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			present  <= 2'b00;
			hob_ena  <= 2'b00;
			use_wait <= 1'b0;
		end else if (mgmt_write && mgmt_address == ide_reg_pkg::MG_CFG6) begin
			if (mgmt_writedata[3]) begin
				{hob_ena[0], present[0]} <= mgmt_writedata[1:0];
			end
			if (mgmt_writedata[7]) begin
				{hob_ena[1], present[1]} <= mgmt_writedata[5:4];
			end
			if (mgmt_writedata[9]) begin
				use_wait <= mgmt_writedata[8];
			end
		end
	end

	// Device control register.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sw_reset <= 1'b0;
		end else if (alt_wr) begin
			sw_reset <= io_writedata[2];
		end
	end

	always_ff @(posedge clk) begin
		if (tf_reset) begin
			disable_irq <= 1'b0;
			hob_pre     <= 1'b0;
		end else if (alt_wr) begin
			disable_irq <= io_writedata[1];
			hob_pre     <= io_writedata[7];
		end
	end

	// High order bytes only for a drive that has 48-bit mode enabled.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hob <= 1'b0;
		end else begin
			hob <= hob_pre && hob_ena[drv_addr[4]];
		end
	end

	always_comb begin
		case (io_address)
			ide_reg_pkg::IO_ERROR:  reg_byte = error;
			ide_reg_pkg::IO_COUNT:  reg_byte = hob ? sector_count[15:8] : sector_count[7:0];
			ide_reg_pkg::IO_SECTOR: reg_byte = hob ? sector[15:8] : sector[7:0];
			ide_reg_pkg::IO_CYL_LO: reg_byte = hob ? cylinder[23:16] : cylinder[7:0];
			ide_reg_pkg::IO_CYL_HI: reg_byte = hob ? cylinder[31:24] : cylinder[15:8];
			ide_reg_pkg::IO_DRIVE:  reg_byte = drv_addr;
			ide_reg_pkg::IO_CMD,
			ide_reg_pkg::IO_ALT:    reg_byte = status;
			ide_reg_pkg::IO_DADDR:  reg_byte = {2'b10, ~drv_addr[3:0], ~drv_addr[4], drv_addr[4]};
			default:                reg_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (io_read) begin
			if (!(|present)) begin
				io_readdata <= 32'hFFFF_FFFF;
			end else if (io_address == ide_reg_pkg::IO_DATA) begin
				io_readdata <= drq ? pio_word : 32'd0;
			end else begin
				io_readdata <= {24'd0, reg_byte};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mgmt_read) begin
			case (mgmt_address)
				ide_reg_pkg::MG_CFG0: begin
					mgmt_readdata <= {features, 5'd0, no_data_in, use_fast, io_done};
				end
				ide_reg_pkg::MG_CFG1: mgmt_readdata <= {sector[7:0], sector_count[7:0]};
				ide_reg_pkg::MG_CFG2: mgmt_readdata <= cylinder[15:0];
				ide_reg_pkg::MG_CFG3: mgmt_readdata <= {sector[15:8], sector_count[15:8]};
				ide_reg_pkg::MG_CFG4: mgmt_readdata <= cylinder[31:16];
				ide_reg_pkg::MG_CFG5: mgmt_readdata <= {cmd, drv_addr};
				ide_reg_pkg::MG_CFG6: begin
					mgmt_readdata <= {7'd0, use_wait, 2'd0, hob_ena[1], present[1], 2'd0,
						hob_ena[0], present[0]};
				end
				ide_reg_pkg::MG_DATA: mgmt_readdata <= mgmt_word;
				default:              mgmt_readdata <= 16'h0000;
			endcase
		end
	end

endmodule

// File: design/ide_buf_sequencer.sv
`timescale 1ns/100ps

module ide_buf_sequencer #(
	parameter int ADDR_W = 12
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        io_32,
	input  logic [3:0]  mgmt_address,
	input  logic        mgmt_read,
	input  logic        mgmt_write,
	input  logic [15:0] mgmt_writedata,
	input  logic [31:0] io_writedata,
	input  logic        pio_wr_stb,
	input  logic        pio_rd_stb,
	input  logic [15:0] blk_size,
	input  logic        fast_read,
	input  logic        drq,
	input  logic        buf_clear,
	output logic        io_done,
	output logic        no_data,
	output logic        io_lsb,
	output logic        mgmt_lsb,
	output logic [ide_buf_pkg::NUM_BANKS-1:0][ADDR_W-1:0]              bank_addr_a,
	output logic [ide_buf_pkg::NUM_BANKS-1:0][ide_buf_pkg::WORD_W-1:0] bank_wdata_a,
	output logic [ide_buf_pkg::NUM_BANKS-1:0]                          bank_wren_a,
	output logic [ide_buf_pkg::NUM_BANKS-1:0][ADDR_W-1:0]              bank_addr_b,
	output logic [ide_buf_pkg::NUM_BANKS-1:0][ide_buf_pkg::WORD_W-1:0] bank_wdata_b,
	output logic [ide_buf_pkg::NUM_BANKS-1:0]                          bank_wren_b
);

	localparam int CW = ide_buf_pkg::CNT_W;
	localparam int WW = ide_buf_pkg::WORD_W;

	logic [CW-1:0] io_cnt;
	logic [CW-1:0] mgmt_cnt;
	logic          io_stb;
	logic          io_stb_d;
	logic          mgmt_stb;
	logic          mgmt_stb_d;
	logic          mgmt_hit_d;
	logic          mgmt_data_wr;
	logic          n_data;
	logic [1:0]    n_data_r;

	assign io_stb       = pio_wr_stb || pio_rd_stb;
	assign mgmt_stb     = mgmt_write || mgmt_read;
	assign mgmt_data_wr = mgmt_write && (mgmt_address == ide_reg_pkg::MG_DATA);

	// Counters step when the access strobe falls.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			io_stb_d   <= 1'b0;
			mgmt_stb_d <= 1'b0;
			mgmt_hit_d <= 1'b0;
			io_cnt     <= '0;
			mgmt_cnt   <= '0;
			n_data_r   <= 2'b00;
		end else begin
			io_stb_d   <= io_stb;
			mgmt_stb_d <= mgmt_stb;
			mgmt_hit_d <= mgmt_address == ide_reg_pkg::MG_DATA;
			n_data_r   <= {n_data_r[0], n_data};
			if (buf_clear) begin
				io_cnt <= '0;
			end else if (io_stb_d && !io_stb) begin
				io_cnt <= io_cnt + (io_32 ? CW'(2) : CW'(1));
			end
			// Any other management access rewinds the software pointer.
			if (mgmt_stb_d && !mgmt_stb) begin
				mgmt_cnt <= mgmt_hit_d ? mgmt_cnt + CW'(1) : '0;
			end
		end
	end

	assign io_done  = (blk_size != 16'h0000) && (16'(io_cnt) >= blk_size);
	assign io_lsb   = io_cnt[0];
	assign mgmt_lsb = mgmt_cnt[0];

	// CPU is about to pass the software in fast read.
	assign n_data  = (mgmt_cnt[CW-1:1] <= io_cnt[CW-1:1]) && drq && fast_read;
	assign no_data = n_data || (|n_data_r);

	for (genvar k = 0; k < ide_buf_pkg::NUM_BANKS; k++) begin : g_steer
		localparam bit ODD = (k % 2) == 1;

		assign bank_addr_a[k]  = mgmt_cnt[ADDR_W:1];
		assign bank_wdata_a[k] = mgmt_writedata;
		assign bank_wren_a[k]  = mgmt_data_wr && (mgmt_cnt[0] == ODD);
		assign bank_addr_b[k]  = io_cnt[ADDR_W:1];
		assign bank_wdata_b[k] = io_32 ? io_writedata[k*WW +: WW] : io_writedata[WW-1:0];
		assign bank_wren_b[k]  = pio_wr_stb && (io_32 || io_cnt[0] == ODD);
	end

endmodule

// File: design/ide_buf_merge.sv
`timescale 1ns/100ps

module ide_buf_merge (
	input  logic                                                       io_32,
	input  logic                                                       io_lsb,
	input  logic                                                       mgmt_lsb,
	input  logic [ide_buf_pkg::NUM_BANKS-1:0][ide_buf_pkg::WORD_W-1:0] q_a,
	input  logic [ide_buf_pkg::NUM_BANKS-1:0][ide_buf_pkg::WORD_W-1:0] q_b,
	output logic [31:0]                                                pio_word,
	output logic [15:0]                                                mgmt_word
);

	logic [ide_buf_pkg::WORD_W-1:0] pio_low;

	// An odd 16-bit word shows up in both halves.
	assign pio_low  = (!io_32 && io_lsb) ? q_b[1] : q_b[0];
	assign pio_word = {q_b[1], pio_low};

	// Software always moves one 16-bit word at a time.
	assign mgmt_word = mgmt_lsb ? q_a[1] : q_a[0];

endmodule

// File: design/ide_buf_bank.sv
`timescale 1ns/100ps

module ide_buf_bank #(
	parameter int ADDR_W = 12
) (
	input  logic                            clk,
	input  logic [ADDR_W-1:0]               addr_a,
	input  logic [ide_buf_pkg::WORD_W-1:0]  wdata_a,
	input  logic                            wren_a,
	input  logic [ADDR_W-1:0]               addr_b,
	input  logic [ide_buf_pkg::WORD_W-1:0]  wdata_b,
	input  logic                            wren_b,
	output logic [ide_buf_pkg::WORD_W-1:0]  q_a,
	output logic [ide_buf_pkg::WORD_W-1:0]  q_b
);

	logic [ide_buf_pkg::WORD_W-1:0] mem [0:(1 << ADDR_W)-1];

	// Write-first on both ports.
	always_ff @(posedge clk) begin
		if (wren_a) begin
			mem[addr_a] <= wdata_a;
			q_a         <= wdata_a;
		end else begin
			q_a <= mem[addr_a];
		end
		if (wren_b) begin
			mem[addr_b] <= wdata_b;
			q_b         <= wdata_b;
		end else begin
			q_b <= mem[addr_b];
		end
	end

endmodule

// File: design/ide_buf_pkg.sv
package ide_buf_pkg;

	// Even and odd word banks.
	localparam int NUM_BANKS = 2;

	// Width of one stored word.
	localparam int WORD_W = 16;

	// Word counters, one bit wider than a full 4096 word buffer needs.
	localparam int CNT_W = 14;

endpackage

// File: design/ide_reg_pkg.sv
package ide_reg_pkg;

	// CPU side task file addresses.
	localparam logic [3:0] IO_DATA   = 4'd0;
	localparam logic [3:0] IO_ERROR  = 4'd1;
	localparam logic [3:0] IO_COUNT  = 4'd2;
	localparam logic [3:0] IO_SECTOR = 4'd3;
	localparam logic [3:0] IO_CYL_LO = 4'd4;
	localparam logic [3:0] IO_CYL_HI = 4'd5;
	localparam logic [3:0] IO_DRIVE  = 4'd6;
	localparam logic [3:0] IO_CMD    = 4'd7;
	localparam logic [3:0] IO_ALT    = 4'd14;
	localparam logic [3:0] IO_DADDR  = 4'd15;

	// Management side addresses.
	localparam logic [3:0] MG_CFG0 = 4'd0;
	localparam logic [3:0] MG_CFG1 = 4'd1;
	localparam logic [3:0] MG_CFG2 = 4'd2;
	localparam logic [3:0] MG_CFG3 = 4'd3;
	localparam logic [3:0] MG_CFG4 = 4'd4;
	localparam logic [3:0] MG_CFG5 = 4'd5;
	localparam logic [3:0] MG_CFG6 = 4'd6;
	localparam logic [3:0] MG_DATA = 4'd15;

	// Status register values.
	localparam logic [7:0] ST_BUSY  = 8'h80;
	localparam logic [7:0] ST_READY = 8'h40;

	// Request codes seen by the emulation software.
	localparam logic [2:0] RQ_RESET = 3'b110;
	localparam logic [2:0] RQ_CMD   = 3'b100;
	localparam logic [2:0] RQ_DATA  = 3'b101;
	localparam logic [2:0] RQ_NONE  = 3'b000;

endpackage
